/* filelist.f */
+incdir+include
hdl/heapPkg.sv
hdl/heapAllocator.sv
hdl/heapDecode.sv
hdl/heapExecute.sv
hdl/heapResult.sv
hdl/arrayHeap.sv
dv/arrayHeapTb.sv

/* Makefile */
# Verilator build and run for the array heap testbench

VERILATOR ?= verilator
TOP       ?= arrayHeapTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "FAIL: see errors above" $(LOG); then \
	  echo "simulation reported failures, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/heapTests.svh */
// request table for the array heap testbench
// columns: name, action, array, index, data, expected data, expected error, row kind
`ifndef heapTestsSvh
`define heapTestsSvh

task automatic loadTable();
  // ----------------------------------------
  // alloc, reuse, double free
  addRow("alloc0",        actAlloc,      0, 0, 'h000, 'h000, errNone,         fixedRow);
  addRow("writeNotAlloc", actWrite,      1, 0, 'h321, 'h000, errNotAllocated, fixedRow);
  addRow("alloc1",        actAlloc,      0, 0, 'h000, 'h001, errNone,         fixedRow);
  addRow("alloc2",        actAlloc,      0, 0, 'h000, 'h002, errNone,         fixedRow);
  addRow("alloc3",        actAlloc,      0, 0, 'h000, 'h003, errNone,         fixedRow);
  addRow("allocFull",     actAlloc,      0, 0, 'h000, 'h000, errNoArrays,     fixedRow);
  addRow("free1",         actFree,       1, 0, 'h000, 'h000, errNone,         fixedRow);
  addRow("freeTwice",     actFree,       1, 0, 'h000, 'h000, errFreed,        fixedRow);
  addRow("allocReuse",    actAlloc,      0, 0, 'h000, 'h001, errNone,         fixedRow);
  // write, read, size on array 0
  addRow("write0",        actWrite,      0, 0, 'h123, 'h123, errNone,         fixedRow);
  addRow("write2",        actWrite,      0, 2, 'h456, 'h456, errNone,         fixedRow);
  addRow("write1",        actWrite,      0, 1, 'h123, 'h123, errNone,         fixedRow);
  addRow("read2",         actRead,       0, 2, 'h000, 'h456, errNone,         fixedRow);
  addRow("read1",         actRead,       0, 1, 'h000, 'h123, errNone,         fixedRow);
  addRow("size0",         actSize,       0, 0, 'h000, 'h003, errNone,         fixedRow);
  addRow("readBounds",    actRead,       0, 3, 'h000, 'h000, errBounds,       fixedRow);
  // stack on array 2
  addRow("push1",         actPush,       2, 0, 'h011, 'h011, errNone,         fixedRow);
  addRow("push2",         actPush,       2, 0, 'h022, 'h022, errNone,         fixedRow);
  addRow("push3",         actPush,       2, 0, 'h033, 'h033, errNone,         fixedRow);
  addRow("push4",         actPush,       2, 0, 'h044, 'h044, errNone,         fixedRow);
  addRow("pushFull",      actPush,       2, 0, 'h055, 'h000, errFull,         fixedRow);
  addRow("pop4",          actPop,        2, 0, 'h000, 'h044, errNone,         fixedRow);
  addRow("pop3",          actPop,        2, 0, 'h000, 'h033, errNone,         fixedRow);
  addRow("pop2",          actPop,        2, 0, 'h000, 'h022, errNone,         fixedRow);
  addRow("pop1",          actPop,        2, 0, 'h000, 'h011, errNone,         fixedRow);
  addRow("popEmpty",      actPop,        2, 0, 'h000, 'h000, errEmpty,        fixedRow);
  // search, array 0 holds 123 123 456
  addRow("indexLast",     actIndex,      0, 0, 'h123, 'h002, errNone,         fixedRow);
  addRow("indexMiss",     actIndex,      0, 0, 'h0aa, 'h000, errNone,         fixedRow);
  addRow("less",          actLess,       0, 0, 'h456, 'h002, errNone,         fixedRow);
  addRow("greater",       actGreater,    0, 0, 'h123, 'h001, errNone,         fixedRow);
  addRow("greaterEmpty",  actGreater,    2, 0, 'h000, 'h000, errNone,         fixedRow);
  // ----------------------------------------
  // arithmetic on array 3 element 0
  addRow("seed",          actWrite,      3, 0, 'h5a5, 'h5a5, errNone,         seedRow);
  addRow("add",           actAdd,        3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("readAdd",       actRead,       3, 0, 'h000, 'h000, errNone,         trackedRow);
  addRow("addAfter",      actAddAfter,   3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("subtract",      actSubtract,   3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("subAfter",      actSubAfter,   3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("readSub",       actRead,       3, 0, 'h000, 'h000, errNone,         trackedRow);
  addRow("shiftLeft",     actShiftLeft,  3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("shiftRight",    actShiftRight, 3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("notLogical",    actNotLogical, 3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("not",           actNot,        3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("or",            actOr,         3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("xor",           actXor,        3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("and",           actAnd,        3, 0, 'h000, 'h000, errNone,         randomRow);
  addRow("readFinal",     actRead,       3, 0, 'h000, 'h000, errNone,         trackedRow);
  addRow("arithBounds",   actAdd,        3, 1, 'h001, 'h000, errBounds,       fixedRow);
  // reset action, dropped code
  addRow("reset",         actReset,      0, 0, 'h000, 'h000, errNone,         fixedRow);
  addRow("sizeNotAlloc",  actSize,       0, 0, 'h000, 'h000, errNotAllocated, fixedRow);
  addRow("readNotAlloc",  actRead,       2, 0, 'h000, 'h000, errNotAllocated, fixedRow);
  addRow("allocRestart",  actAlloc,      0, 0, 'h000, 'h000, errNone,         fixedRow);
  addRow("badAction",     8'd10,         0, 0, 'h7ff, 'h000, errBadAction,    fixedRow);
endtask

`endif

/* dv/arrayHeapTb.sv */
// testbench for the array heap
// table loop over requests, random operands for the arithmetic rows,
// per-test result lines, cycle limit and summary
`timescale 1ns/10ps
`default_nettype none

module arrayHeapTb;
  import heapPkg::*;

  localparam int addressBits = 2;
  localparam int indexBits   = 2;
  localparam int dataBits    = 12;
  localparam int halfPeriod  = 20;   // 40 ns clock
  localparam int doneWait    = 4;    // negedges to wait for done
  localparam int doneLatency = 2;    // cycles from the sampling edge to done

  // row kinds
  localparam int fixedRow   = 0;  // expected values straight from the table
  localparam int seedRow    = 1;  // write that sets the tracked element
  localparam int randomRow  = 2;  // random operand with a modelled result
  localparam int trackedRow = 3;  // read that expects the tracked element

  logic                   clock;
  logic                   resetN;
  logic                   start;
  logic [7:0]             action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    dataIn;
  logic [dataBits-1:0]    dataOut;
  heapError_t             error;
  logic                   done;

  string                  testName[$];
  logic [7:0]             testAction[$];
  logic [addressBits-1:0] testArray[$];
  logic [indexBits-1:0]   testIndex[$];
  logic [dataBits-1:0]    testData[$];
  logic [dataBits-1:0]    testExpData[$];
  heapError_t             testExpError[$];
  int                     testMode[$];

  logic [31:0] randState;
  int          cycles = 0;
  int          cycleLimit = 0;   // set once the table is loaded

  arrayHeap #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) dut0 (
    .clock(clock), .resetN(resetN), .start(start), .action(action),
    .array(array), .index(index), .dataIn(dataIn),
    .dataOut(dataOut), .error(error), .done(done)
  );

  always #(halfPeriod) clock = ~clock;

  always @(posedge clock) cycles <= cycles + 1;

  // ----------------------------------------
  task automatic addRow(input string name, input logic [7:0] act, input int arr,
                        input int idx, input int data, input int expData,
                        input heapError_t expError, input int mode);
    testName.push_back(name);
    testAction.push_back(act);
    testArray.push_back(addressBits'(arr));
    testIndex.push_back(indexBits'(idx));
    testData.push_back(dataBits'(data));
    testExpData.push_back(dataBits'(expData));
    testExpError.push_back(expError);
    testMode.push_back(mode);
  endtask

  `include "heapTests.svh"

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // element update rules for the arithmetic group
  function automatic logic [dataBits-1:0] applyOp(input logic [7:0] op,
                                                  input logic [dataBits-1:0] a,
                                                  input logic [dataBits-1:0] b);
    logic [dataBits-1:0] r;
    case (op)
      actAdd, actAddAfter:      r = a + b;
      actSubtract, actSubAfter: r = a - b;
      actShiftLeft:             r = a << b;
      actShiftRight:            r = a >> b;
      actNotLogical:            r = (a == '0) ? dataBits'(1) : '0;
      actNot:                   r = ~a;
      actOr:                    r = a | b;
      actXor:                   r = a ^ b;
      actAnd:                   r = a & b;
      default:                  r = a;
    endcase
    return r;
  endfunction

  // ----------------------------------------
  // run limit
  initial begin
    wait (cycleLimit > 0);
    wait (cycles >= cycleLimit);
    $display("run stopped after %0d cycles, the tests did not finish", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int                  row;
    int                  waited;
    int                  passed;
    int                  failed;
    logic [dataBits-1:0] sendData;
    logic [dataBits-1:0] expData;
    logic [dataBits-1:0] newValue;
    logic [dataBits-1:0] tracked;   // model of the element under test
    clock     = 1'b0;
    resetN    = 1'b0;
    start     = 1'b0;
    action    = '0;
    array     = '0;
    index     = '0;
    dataIn    = '0;
    tracked   = '0;
    passed    = 0;
    failed    = 0;
    randState = 32'he5517f55;
    loadTable();
    cycleLimit = 4 * testName.size() + 20;
    repeat (4) @(posedge clock);
    #2 resetN = 1'b1;

    for (row = 0; row < testName.size(); row++) begin
      sendData = testData[row];
      expData  = testExpData[row];
      if (testMode[row] == randomRow) begin
        randState = xorshift(randState);
        sendData  = randState[dataBits-1:0];
        if (testAction[row] == actShiftLeft || testAction[row] == actShiftRight)
          sendData = dataBits'(randState[1:0]) + 1'b1;  // shift by 1..4
        newValue = applyOp(testAction[row], tracked, sendData);
        if (testAction[row] == actAddAfter || testAction[row] == actSubAfter)
          expData = tracked;   // old value comes back
        else
          expData = newValue;
        tracked = newValue;
      end else if (testMode[row] == seedRow) begin
        tracked = sendData;
      end else if (testMode[row] == trackedRow) begin
        expData = tracked;
      end

      start  = 1'b1;
      action = testAction[row];
      array  = testArray[row];
      index  = testIndex[row];
      dataIn = sendData;
      @(posedge clock);
      #2 start = 1'b0;

      // outputs settled by the falling edge
      waited = 0;
      @(negedge clock);
      while (!done && waited < doneWait) begin
        @(negedge clock);
        waited++;
      end

      if (!done) begin
        $display("%s: no done pulse came back for this request", testName[row]);
        failed++;
      end else if (waited != doneLatency) begin
        $display("%s: done came %0d cycles after the request instead of %0d",
                 testName[row], waited, doneLatency);
        failed++;
      end else if (dataOut !== expData || error !== testExpError[row]) begin
        $display("ERROR %s: expected data %h error %0d, actual data %h error %0d",
                 testName[row], expData, testExpError[row], dataOut, error);
        failed++;
      end else begin
        $display("ok    %s", testName[row]);
        passed++;
      end
      @(posedge clock);
      #2;
    end

    $display("%0d tests, %0d passed, %0d failed", testName.size(), passed, failed);
    if (failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/arrayHeap.sv */
// array heap top level
// decode, execute and result stages wired in a row
`timescale 1ns/10ps
`default_nettype none

module arrayHeap #(
  parameter int addressBits = 2,   // arrays = 2**addressBits
  parameter int indexBits   = 2,   // elements per array = 2**indexBits
  parameter int dataBits    = 12   // element width
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   start,    // one-cycle request strobe
  input  logic [7:0]             action,   // raw action code
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic [dataBits-1:0]    dataOut,
  output heapPkg::heapError_t    error,
  output logic                   done      // one pulse per request
);
  import heapPkg::*;

  heapCommand_t            command;        // decoded request
  logic [addressBits-1:0]  commandArray;
  logic [indexBits-1:0]    commandIndex;
  logic [dataBits-1:0]     commandData;
  heapOutcome_t            outcome;        // execute status
  logic [dataBits-1:0]     resultData;

  // ----------------------------------------
  heapDecode #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) decode0 (
    .clock(clock), .resetN(resetN), .start(start), .action(action),
    .array(array), .index(index), .dataIn(dataIn),
    .command(command), .commandArray(commandArray),
    .commandIndex(commandIndex), .commandData(commandData)
  );

  heapExecute #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits)) execute0 (
    .clock(clock), .resetN(resetN), .command(command),
    .commandArray(commandArray), .commandIndex(commandIndex), .commandData(commandData),
    .outcome(outcome), .resultData(resultData)
  );

  heapResult #(.dataBits(dataBits)) result0 (
    .clock(clock), .resetN(resetN), .outcome(outcome), .resultData(resultData),
    .dataOut(dataOut), .error(error), .done(done)
  );

endmodule

`default_nettype wire

/* hdl/heapResult.sv */
// result register
// output word, error code and done pulse
`timescale 1ns/10ps
`default_nettype none

module heapResult #(
  parameter int dataBits = 12
) (
  input  logic                  clock,
  input  logic                  resetN,
  input  heapPkg::heapOutcome_t outcome,
  input  logic [dataBits-1:0]   resultData,
  output logic [dataBits-1:0]   dataOut,
  output heapPkg::heapError_t   error,
  output logic                  done
);
  import heapPkg::*;

  logic keepData;   // word goes out only on success with data

  assign keepData = outcome.dataValid && (outcome.error == errNone);

  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) done <= 1'b0;
    else         done <= outcome.valid;  // one pulse per finished request
  end

  always_ff @(posedge clock) begin
    if (outcome.valid) begin
      error   <= outcome.error;
      dataOut <= keepData ? resultData : '0;  // zero on any error
    end
  end

endmodule

`default_nettype wire

/* hdl/heapExecute.sv */
// execute stage: element memory, array sizes, request checks
// arithmetic, search, push/pop, alloc and free
`timescale 1ns/10ps
`default_nettype none

module heapExecute #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  heapPkg::heapCommand_t  command,
  input  logic [addressBits-1:0] commandArray,
  input  logic [indexBits-1:0]   commandIndex,
  input  logic [dataBits-1:0]    commandData,
  output heapPkg::heapOutcome_t  outcome,
  output logic [dataBits-1:0]    resultData
);
  import heapPkg::*;

  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;
  localparam int countBits   = indexBits + 1;   // sizes run 0..arrayLength

  logic [dataBits-1:0]    memory [arrays][arrayLength];  // fixed block per array
  logic [countBits-1:0]   sizes  [arrays];

  logic [countBits-1:0]   arraySize;    // size of addressed array
  logic [dataBits-1:0]    oldValue;
  logic [dataBits-1:0]    newValue;
  logic [countBits-1:0]   matchCount;   // index / less / greater result
  logic [indexBits-1:0]   popIndex;
  heapError_t             accessCode;
  heapError_t             errorCode;
  logic                   dataValid;
  logic                   memWrite;
  logic [indexBits-1:0]   memIndex;
  logic [dataBits-1:0]    memData;
  logic                   sizeWrite;
  logic [addressBits-1:0] sizeArray;
  logic [countBits-1:0]   sizeValue;
  logic                   allocate, deallocate, clearAll;
  logic [addressBits-1:0] allocatedArray;
  logic                   allocOk;
  logic [arrays-1:0]      isAllocated;
  logic [addressBits:0]   handedOut;

  heapAllocator #(.addressBits(addressBits)) allocator0 (
    .clock(clock), .resetN(resetN), .allocate(allocate), .deallocate(deallocate),
    .clearAll(clearAll), .releaseArray(commandArray),
    .allocatedArray(allocatedArray), .allocOk(allocOk),
    .isAllocated(isAllocated), .handedOut(handedOut)
  );

  assign arraySize = sizes[commandArray];
  assign oldValue  = memory[commandArray][commandIndex];
  assign popIndex  = arraySize[indexBits-1:0] - 1'b1;  // wraps right when full

  // ----------------------------------------
  // access checks, never issued, then freed, then bounds
  always_comb begin
    accessCode = errNone;
    if ({1'b0, commandArray} >= handedOut)                           accessCode = errNotAllocated;
    else if (!isAllocated[commandArray])                             accessCode = errFreed;
    else if (command.boundsCheck && {1'b0, commandIndex} >= arraySize) accessCode = errBounds;
  end

  always_comb begin
    case (command.action)
      actAdd, actAddAfter:      newValue = oldValue + commandData;
      actSubtract, actSubAfter: newValue = oldValue - commandData;
      actShiftLeft:             newValue = oldValue << commandData;
      actShiftRight:            newValue = oldValue >> commandData;
      actNotLogical:            newValue = {{(dataBits-1){1'b0}}, ~|oldValue};
      actNot:                   newValue = ~oldValue;
      actOr:                    newValue = oldValue | commandData;
      actXor:                   newValue = oldValue ^ commandData;
      actAnd:                   newValue = oldValue & commandData;
      default:                  newValue = oldValue;
    endcase
  end

  // search over occupied elements only
  always_comb begin
    matchCount = '0;
    for (int i = 0; i < arrayLength; i++) begin
      if (i < arraySize) begin
        case (command.action)
          actIndex:   if (memory[commandArray][i] == commandData) matchCount = countBits'(i + 1);
          actLess:    if (memory[commandArray][i] < commandData) matchCount = matchCount + 1'b1;
          actGreater: if (memory[commandArray][i] > commandData) matchCount = matchCount + 1'b1;
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------
  // operation select, state updates land on the next edge
  always_comb begin
    errorCode  = errNone;
    resultData = '0;
    dataValid  = 1'b0;
    memWrite   = 1'b0;
    memIndex   = commandIndex;
    memData    = newValue;
    sizeWrite  = 1'b0;
    sizeArray  = commandArray;
    sizeValue  = arraySize;
    allocate   = 1'b0;
    deallocate = 1'b0;
    clearAll   = 1'b0;
    if (command.valid) begin
      if (!command.known) begin
        errorCode = errBadAction;
      end else if (command.action == actReset) begin
        clearAll = 1'b1;
      end else if (command.action == actAlloc) begin
        allocate = 1'b1;
        if (allocOk) begin
          sizeWrite  = 1'b1;          // fresh array starts empty
          sizeArray  = allocatedArray;
          sizeValue  = '0;
          resultData = dataBits'(allocatedArray);
          dataValid  = 1'b1;
        end else begin
          errorCode = errNoArrays;
        end
      end else if (accessCode != errNone) begin
        errorCode = accessCode;
      end else begin
        dataValid = 1'b1;
        case (command.action)
          actWrite: begin
            memWrite   = 1'b1;
            memData    = commandData;
            sizeWrite  = ({1'b0, commandIndex} >= arraySize);
            sizeValue  = {1'b0, commandIndex} + 1'b1;
            resultData = commandData;
          end
          actRead:                      resultData = oldValue;
          actSize:                      resultData = dataBits'(arraySize);
          actIndex, actLess, actGreater: resultData = dataBits'(matchCount);
          actPush: begin
            if (arraySize < arrayLength) begin
              memWrite   = 1'b1;
              memIndex   = arraySize[indexBits-1:0];
              memData    = commandData;
              sizeWrite  = 1'b1;
              sizeValue  = arraySize + 1'b1;
              resultData = commandData;
            end else begin
              errorCode = errFull;
            end
          end
          actPop: begin
            if (arraySize != '0) begin
              sizeWrite  = 1'b1;
              sizeValue  = arraySize - 1'b1;
              resultData = memory[commandArray][popIndex];
            end else begin
              errorCode = errEmpty;
            end
          end
          actFree: begin
            deallocate = 1'b1;
            dataValid  = 1'b0;
          end
          actAddAfter, actSubAfter: begin
            memWrite   = 1'b1;
            resultData = oldValue;      // value before the update
          end
          actAdd, actSubtract, actShiftLeft, actShiftRight, actNotLogical,
          actNot, actOr, actXor, actAnd: begin
            memWrite   = 1'b1;
            resultData = newValue;
          end
          default: dataValid = 1'b0;
        endcase
      end
    end
  end

  assign outcome = '{valid: command.valid, dataValid: dataValid, error: errorCode};

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)        sizes <= '{default: '0};
    else if (clearAll)  sizes <= '{default: '0};
    else if (sizeWrite) sizes[sizeArray] <= sizeValue;
  end

  always_ff @(posedge clock) begin
    if (memWrite) memory[commandArray][memIndex] <= memData;
  end

endmodule

`default_nettype wire

/* hdl/heapDecode.sv */
// request capture and action decode
// two register stages, raw request then decoded command
`timescale 1ns/10ps
`default_nettype none

module heapDecode #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                         clock,
  input  logic                         resetN,
  input  logic                         start,
  input  logic [7:0]                   action,
  input  logic [addressBits-1:0]       array,
  input  logic [indexBits-1:0]         index,
  input  logic [dataBits-1:0]          dataIn,
  output heapPkg::heapCommand_t        command,
  output logic [addressBits-1:0]       commandArray,
  output logic [indexBits-1:0]         commandIndex,
  output logic [dataBits-1:0]          commandData
);
  import heapPkg::*;

  logic                    reqValid;   // raw request held
  logic [7:0]              reqAction;
  logic [addressBits-1:0]  reqArray;
  logic [indexBits-1:0]    reqIndex;
  logic [dataBits-1:0]     reqData;
  heapCommand_t            decoded;

  // ----------------------------------------
  // stage 1, sample on start
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) reqValid <= 1'b0;
    else         reqValid <= start;
  end

  always_ff @(posedge clock) begin
    if (start) begin
      reqAction <= action;
      reqArray  <= array;
      reqIndex  <= index;
      reqData   <= dataIn;
    end
  end

  // action byte -> command fields
  always_comb begin
    decoded.valid       = reqValid;
    decoded.action      = heapAction_t'(reqAction);
    decoded.known       = 1'b1;
    decoded.boundsCheck = 1'b0;
    case (reqAction)
      8'd1, 8'd2, 8'd4, 8'd7, 8'd8, 8'd9, 8'd14, 8'd15, 8'd18, 8'd19: ;
      8'd3, 8'd20, 8'd21, 8'd22, 8'd23, 8'd24, 8'd25, 8'd26, 8'd27, 8'd28, 8'd29, 8'd30:
        decoded.boundsCheck = 1'b1;  // read and element arithmetic
      default: decoded.known = 1'b0;   // includes dropped codes
    endcase
  end

  // stage 2, decoded command register
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) command <= '0;
    else         command <= decoded;
  end

  always_ff @(posedge clock) begin
    if (reqValid) begin
      commandArray <= reqArray;
      commandIndex <= reqIndex;
      commandData  <= reqData;
    end
  end

endmodule

`default_nettype wire

/* hdl/heapAllocator.sv */
// array allocator
// free stack of released numbers, allocation flags, count of arrays issued
`timescale 1ns/10ps
`default_nettype none

module heapAllocator #(
  parameter int addressBits = 2
) (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          allocate,        // alloc request this cycle
  input  logic                          deallocate,      // free request, already checked
  input  logic                          clearAll,        // reset action
  input  logic [addressBits-1:0]        releaseArray,
  output logic [addressBits-1:0]        allocatedArray,
  output logic                          allocOk,
  output logic [2**addressBits-1:0]     isAllocated,
  output logic [addressBits:0]          handedOut        // arrays ever issued
);

  localparam int arrays = 2 ** addressBits;

  logic [addressBits-1:0] freeStack [arrays];
  logic [addressBits:0]   freeTop;       // entries on the free stack
  logic [addressBits:0]   stackIndex;

  // ----------------------------------------
  // pick a number, most recently freed first
  always_comb begin
    stackIndex     = freeTop - 1'b1;
    allocatedArray = '0;
    allocOk        = 1'b0;
    if (freeTop != '0) begin
      allocatedArray = freeStack[stackIndex[addressBits-1:0]];
      allocOk        = 1'b1;
    end else if (handedOut < arrays) begin
      allocatedArray = handedOut[addressBits-1:0];  // next never-used array
      allocOk        = 1'b1;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freeTop     <= '0;
      handedOut   <= '0;
      isAllocated <= '0;
    end else if (clearAll) begin
      freeTop     <= '0;
      handedOut   <= '0;
      isAllocated <= '0;
    end else if (allocate && allocOk) begin
      isAllocated[allocatedArray] <= 1'b1;
      if (freeTop != '0) freeTop   <= freeTop - 1'b1;  // reuse
      else               handedOut <= handedOut + 1'b1;
    end else if (deallocate) begin
      isAllocated[releaseArray] <= 1'b0;
      freeTop                   <= freeTop + 1'b1;
    end
  end

  // stack contents, no reset
  always_ff @(posedge clock) begin
    if (deallocate && !clearAll) freeStack[freeTop[addressBits-1:0]] <= releaseArray;
  end

endmodule

`default_nettype wire

/* hdl/heapPkg.sv */
// shared types for the array heap
// action codes, error codes, decoded command and execute outcome
`default_nettype none

package heapPkg;

  // ----------------------------------------
  // action codes
  // codes 5, 6, 10..13, 16 and 17 are not supported and decode as unknown
  typedef enum logic [7:0] {
    actReset      = 8'd1,   // drop every array, sizes back to zero
    actWrite      = 8'd2,   // store element, grows size to index+1
    actRead       = 8'd3,   // fetch element below size
    actSize       = 8'd4,   // current element count
    actIndex      = 8'd7,   // 1-based position of last match, 0 if none
    actLess       = 8'd8,   // count of elements below data
    actGreater    = 8'd9,   // count of elements above data
    actPush       = 8'd14,  // append at size
    actPop        = 8'd15,  // remove and return last element
    actAlloc      = 8'd18,  // hand out an array number
    actFree       = 8'd19,  // give an array back
    actAdd        = 8'd20,  // returns new value
    actAddAfter   = 8'd21,  // returns old value
    actSubtract   = 8'd22,  // returns new value
    actSubAfter   = 8'd23,  // returns old value
    actShiftLeft  = 8'd24,
    actShiftRight = 8'd25,
    actNotLogical = 8'd26,  // element becomes 0 or 1
    actNot        = 8'd27,  // bitwise invert
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } heapAction_t;

  // ----------------------------------------
  // error codes, one per kind of fault
  typedef enum logic [3:0] {
    errNone         = 4'd0,  // request done
    errNotAllocated = 4'd1,  // array number never handed out
    errFreed        = 4'd2,  // array currently on the free stack
    errBounds       = 4'd3,  // index at or past array size
    errFull         = 4'd4,  // push onto full array
    errEmpty        = 4'd5,  // pop from empty array
    errNoArrays     = 4'd6,  // every array in use on alloc
    errBadAction    = 4'd7   // unsupported action code
  } heapError_t;

  // decoded request, decode -> execute
  typedef struct packed {
    logic        valid;        // request present this cycle
    logic        known;        // supported action code
    logic        boundsCheck;  // index has to be below size
    heapAction_t action;
  } heapCommand_t;

  // execute -> result
  typedef struct packed {
    logic       valid;      // a request finished this cycle
    logic       dataValid;  // result word carries data
    heapError_t error;
  } heapOutcome_t;

endpackage

`default_nettype wire
